// File: rtl/csr_pkg.sv
// ==============================
// CSR block shared definitions
// Address map, widths, feature constants, enums
// ==============================
package csr_pkg;

    // Block geometry, one word is 64 bits
    localparam int CSR_WORDS = 8;
    typedef logic [$clog2(CSR_WORDS)-1:0] csr_idx_t;
    typedef logic [15:0] mmio_addr_t;

    // Transaction tag and data
    localparam int TID_W = 9;
    typedef logic [TID_W-1:0] tid_t;
    typedef logic [63:0] csr_data_t;

    // Word indices inside the block
    localparam csr_idx_t IDX_DFH = csr_idx_t'(0);
    localparam csr_idx_t IDX_UID_L = csr_idx_t'(1);
    localparam csr_idx_t IDX_UID_H = csr_idx_t'(2);
    // Control words, host writes only
    localparam csr_idx_t IDX_MODE = csr_idx_t'(3);
    localparam csr_idx_t IDX_PT_BASE = csr_idx_t'(4);
    // Statistics words
    localparam csr_idx_t IDX_STAT_HITS = csr_idx_t'(5);
    localparam csr_idx_t IDX_STAT_MISSES = csr_idx_t'(6);
    localparam csr_idx_t IDX_STAT_WALK = csr_idx_t'(7);

    // Statistics buckets
    localparam int NUM_STATS = 3;
    typedef logic [15:0] stat_cnt_t;
    typedef csr_idx_t [NUM_STATS-1:0] stat_idx_vec_t;
    typedef stat_cnt_t [NUM_STATS-1:0] stat_cnt_vec_t;

    // Feature identity
    localparam logic [127:0] FEATURE_UID = 128'h3f6e91d2_0b47_4c8a_9e15_d27a60c4b8f3;
    localparam logic [3:0] FTYPE_BBB = 4'd2;
    localparam int DFH_NEXT_BYTES = CSR_WORDS * 8;

    // Device feature header, single entry so end-of-list is always set
    function automatic csr_data_t dfh_build(input int instance_id);
        csr_data_t dfh;
        dfh = '0;
        dfh[11:0] = 12'(instance_id);
        dfh[39:16] = 24'(DFH_NEXT_BYTES);
        dfh[40] = 1'b1;
        dfh[63:60] = FTYPE_BBB;
        return dfh;
    endfunction

    typedef enum logic {MMIO_READ = 1'b0, MMIO_WRITE = 1'b1} mmio_op_e;
    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT_RD, ST_WRITEBACK} stat_state_e;

endpackage

// File: rtl/csr_if.sv
// ==============================
// CSR block internal interfaces
// Read queue, stats hand-over, memory ports
// ==============================
`timescale 1ns/1ps

// Head of the read request queue
interface mmio_req_if;
    import csr_pkg::*;

    logic valid;
    csr_idx_t idx;
    tid_t tid;
    // One-cycle pop of the head
    logic deq;

    modport queue (output valid, idx, tid, input deq);
    modport consumer (input valid, idx, tid, output deq);
endinterface

// Four-phase bucket hand-over
interface stat_upd_if;
    import csr_pkg::*;

    logic req;
    logic ack;
    stat_idx_vec_t idx_vec;
    stat_cnt_vec_t cnt_vec;

    modport producer (output req, idx_vec, cnt_vec, input ack);
    modport folder (input req, idx_vec, cnt_vec, output ack);
endinterface

// One client port of the backing memory
interface csr_mem_if;
    import csr_pkg::*;

    logic rd_en;
    csr_idx_t rd_idx;
    // Shared memory idle flag
    logic rd_rdy;
    csr_data_t rd_val;
    logic rd_valid;
    logic wr_en;
    csr_idx_t wr_idx;
    csr_data_t wr_val;

    modport client (output rd_en, rd_idx, wr_en, wr_idx, wr_val,
                    input rd_rdy, rd_val, rd_valid);
    modport mem (input rd_en, rd_idx, wr_en, wr_idx, wr_val,
                 output rd_rdy, rd_val, rd_valid);
endinterface

// File: rtl/csr_mmio_decode.sv
// ==============================
// MMIO request decode
// Control writes and queued in-range reads
// ==============================
`timescale 1ns/1ps

module csr_mmio_decode #(
    parameter int CSR_BASE = 16,
    parameter int REQ_DEPTH = 64
) (
    input  logic clk,
    input  logic reset,
    input  logic mmio_valid,
    input  csr_pkg::mmio_op_e mmio_op,
    input  csr_pkg::mmio_addr_t mmio_addr,
    input  csr_pkg::tid_t mmio_tid,
    input  csr_pkg::csr_data_t mmio_wdata,
    output logic mode_enable,
    output logic inval_pulse,
    output csr_pkg::csr_data_t pt_base,
    output logic pt_base_valid,
    mmio_req_if.queue q
);
    import csr_pkg::*;

    localparam int PTR_W = $clog2(REQ_DEPTH);

    // Registered host request
    logic valid_q;
    mmio_op_e op_q;
    mmio_addr_t addr_q;
    tid_t tid_q;
    csr_data_t wdata_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= mmio_valid;
        op_q <= mmio_op;
        addr_q <= mmio_addr;
        tid_q <= mmio_tid;
        wdata_q <= mmio_wdata;
    end

    // Range check and word index
    mmio_addr_t offset;
    logic in_range;
    csr_idx_t idx;
    logic wr_hit;
    logic rd_hit;

    assign offset = addr_q - mmio_addr_t'(CSR_BASE);
    assign in_range = (addr_q >= mmio_addr_t'(CSR_BASE)) &&
                      (addr_q < mmio_addr_t'(CSR_BASE + CSR_WORDS));
    assign idx = offset[$bits(csr_idx_t)-1:0];
    assign wr_hit = valid_q && (op_q == MMIO_WRITE) && in_range;
    assign rd_hit = valid_q && (op_q == MMIO_READ) && in_range;

    // ==============================
    // Control writes
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mode_enable <= 1'b0;
            inval_pulse <= 1'b0;
            pt_base_valid <= 1'b0;
        end
        else
        begin
            // Invalidate lasts one cycle
            inval_pulse <= 1'b0;
            if (wr_hit && (idx == IDX_MODE))
            begin
                mode_enable <= wdata_q[0];
                inval_pulse <= wdata_q[1];
            end
            if (wr_hit && (idx == IDX_PT_BASE))
                pt_base_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_hit && (idx == IDX_PT_BASE))
            pt_base <= wdata_q;
    end

    // ==============================
    // Read request FIFO
    // ==============================
    csr_idx_t fifo_idx [REQ_DEPTH];
    tid_t fifo_tid [REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic full;
    logic push;

    assign full = (count == (PTR_W+1)'(REQ_DEPTH));
    assign push = rd_hit && !full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (q.deq)
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Push and pop together leave the count alone
            if (push && !q.deq)
                count <= count + 1'b1;
            else if (!push && q.deq)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_idx[wr_ptr] <= idx;
            fifo_tid[wr_ptr] <= tid_q;
        end
    end

    assign q.valid = (count != '0);
    assign q.idx = fifo_idx[rd_ptr];
    assign q.tid = fifo_tid[rd_ptr];

    // In-range read dropped because the responder fell behind
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        !(rd_hit && full));

endmodule

// File: rtl/csr_mmio_responder.sv
// ==============================
// MMIO read responder
// One read at a time, response held for host
// ==============================
`timescale 1ns/1ps

module csr_mmio_responder (
    input  logic clk,
    input  logic reset,
    mmio_req_if.consumer q,
    csr_mem_if.client mem,
    output logic rsp_valid,
    output csr_pkg::tid_t rsp_tid,
    output csr_pkg::csr_data_t rsp_data,
    input  logic rsp_ready
);
    import csr_pkg::*;

    // Memory read outstanding
    logic busy;
    logic start;

    // Pop only when nothing is pending anywhere in this stage
    assign start = q.valid && !busy && !rsp_valid && mem.rd_rdy;

    assign q.deq = start;
    assign mem.rd_en = start;
    assign mem.rd_idx = q.idx;
    // Read-only port
    assign mem.wr_en = 1'b0;
    assign mem.wr_idx = '0;
    assign mem.wr_val = '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (start)
                busy <= 1'b1;
            else if (busy && mem.rd_valid)
                busy <= 1'b0;

            if (busy && mem.rd_valid)
                rsp_valid <= 1'b1;
            else if (rsp_valid && rsp_ready)
                rsp_valid <= 1'b0;
        end
    end

    // Tag and data stay put until the host takes them
    always_ff @(posedge clk)
    begin
        if (start)
            rsp_tid <= q.tid;
        if (busy && mem.rd_valid)
            rsp_data <= mem.rd_val;
    end

endmodule

// File: rtl/csr_event_counters.sv
// ==============================
// Event counters
// 16-bit buckets, periodic hand-over
// ==============================
`timescale 1ns/1ps

module csr_event_counters #(
    parameter int STAT_PERIOD = 1024
) (
    input  logic clk,
    input  logic reset,
    input  logic ev_hit_c0,
    input  logic ev_hit_c1,
    input  logic ev_miss,
    input  logic ev_walk_busy,
    stat_upd_if.producer upd
);
    import csr_pkg::*;

    localparam int TMR_W = $clog2(STAT_PERIOD);

    logic [TMR_W-1:0] timer;
    logic period_done;
    logic handover;

    // Live buckets and their registered increments
    stat_cnt_vec_t buckets;
    logic [NUM_STATS-1:0][1:0] incr;

    assign period_done = (timer == TMR_W'(STAT_PERIOD - 1));
    // Wait out a previous exchange before starting a new one
    assign handover = period_done && !upd.req && !upd.ack;

    // Fixed word for each bucket
    assign upd.idx_vec[0] = IDX_STAT_HITS;
    assign upd.idx_vec[1] = IDX_STAT_MISSES;
    assign upd.idx_vec[2] = IDX_STAT_WALK;

    // ==============================
    // Period timer and req
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            timer <= '0;
            upd.req <= 1'b0;
        end
        else
        begin
            if (handover)
                timer <= '0;
            else if (!period_done)
                timer <= timer + 1'b1;

            if (handover)
                upd.req <= 1'b1;
            else if (upd.ack)
                upd.req <= 1'b0;
        end
    end

    // ==============================
    // Buckets
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            incr <= '0;
            buckets <= '0;
        end
        else
        begin
            // Both hit channels summed
            incr[0] <= 2'(ev_hit_c0) + 2'(ev_hit_c1);
            incr[1] <= 2'(ev_miss);
            incr[2] <= 2'(ev_walk_busy);
            // Restart from this cycle's increment so no event is lost
            for (int s = 0; s < NUM_STATS; s++)
                buckets[s] <= (handover ? stat_cnt_t'(0) : buckets[s]) + stat_cnt_t'(incr[s]);
        end
    end

    // Snapshot held for the folder while req is high
    always_ff @(posedge clk)
    begin
        if (handover)
            upd.cnt_vec <= buckets;
    end

endmodule

// File: rtl/csr_stat_folder.sv
// ==============================
// Statistics folder
// Read-add-write of each bucket into memory
// ==============================
`timescale 1ns/1ps

module csr_stat_folder (
    input  logic clk,
    input  logic reset,
    stat_upd_if.folder upd,
    csr_mem_if.client mem
);
    import csr_pkg::*;

    localparam int ENT_W = $clog2(NUM_STATS);

    stat_state_e state;
    logic [ENT_W-1:0] ent;
    logic last;

    // Latched hand-over vectors
    stat_idx_vec_t idx_q;
    stat_cnt_vec_t cnt_q;
    csr_data_t sum_q;

    assign last = (ent == ENT_W'(NUM_STATS - 1));

    // Memory only accepts requests while idle
    assign mem.rd_en = (state == ST_ISSUE) && mem.rd_rdy;
    assign mem.rd_idx = idx_q[ent];
    assign mem.wr_en = (state == ST_WRITEBACK) && mem.rd_rdy;
    assign mem.wr_idx = idx_q[ent];
    assign mem.wr_val = sum_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            ent <= '0;
            upd.ack <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // Finish the last exchange before taking a new one
                    if (upd.ack)
                    begin
                        if (!upd.req)
                            upd.ack <= 1'b0;
                    end
                    else if (upd.req)
                    begin
                        ent <= '0;
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE:
                    if (mem.rd_en)
                        state <= ST_WAIT_RD;
                ST_WAIT_RD:
                begin
                    if (mem.rd_valid)
                        state <= ST_WRITEBACK;
                    // Memory went idle without our data, responder won
                    else if (mem.rd_rdy)
                        state <= ST_ISSUE;
                end
                ST_WRITEBACK:
                    if (mem.wr_en)
                    begin
                        if (last)
                        begin
                            upd.ack <= 1'b1;
                            state <= ST_IDLE;
                        end
                        else
                        begin
                            ent <= ent + 1'b1;
                            state <= ST_ISSUE;
                        end
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && !upd.ack && upd.req)
        begin
            idx_q <= upd.idx_vec;
            cnt_q <= upd.cnt_vec;
        end
        if ((state == ST_WAIT_RD) && mem.rd_valid)
            sum_q <= mem.rd_val + csr_data_t'(cnt_q[ent]);
    end

endmodule

// File: rtl/csr_backing_mem.sv
// ==============================
// CSR backing memory
// Two read clients, two-cycle read
// ==============================
`timescale 1ns/1ps

module csr_backing_mem #(
    parameter int INSTANCE_ID = 1
) (
    input  logic clk,
    input  logic reset,
    csr_mem_if.mem mmio_port,
    csr_mem_if.mem stat_port
);
    import csr_pkg::*;

    csr_data_t mem [CSR_WORDS];

    // Read address held while the data settles
    logic [1:0] rd_active;
    logic rd_rdy;
    logic rd_owner_stat;
    csr_idx_t rd_addr;
    csr_data_t rd_data;
    logic mmio_grant;
    logic stat_grant;

    assign rd_rdy = ~(|rd_active);
    // Responder first, folder retries
    assign mmio_grant = mmio_port.rd_en;
    assign stat_grant = stat_port.rd_en && !mmio_port.rd_en;
    assign rd_data = mem[rd_addr];

    assign mmio_port.rd_rdy = rd_rdy;
    assign stat_port.rd_rdy = rd_rdy;
    assign mmio_port.rd_val = rd_data;
    assign stat_port.rd_val = rd_data;
    assign mmio_port.rd_valid = rd_active[1] && !rd_owner_stat;
    assign stat_port.rd_valid = rd_active[1] && rd_owner_stat;

    always_ff @(posedge clk)
    begin
        if (reset)
            rd_active <= 2'b00;
        else
            rd_active <= {rd_active[0], mmio_grant || stat_grant};
        if (mmio_grant || stat_grant)
        begin
            rd_addr <= mmio_grant ? mmio_port.rd_idx : stat_port.rd_idx;
            rd_owner_stat <= stat_grant;
        end
    end

    // Reset loads the feature header and UID, everything else is zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int w = 0; w < CSR_WORDS; w++)
                mem[w] <= '0;
            mem[IDX_DFH] <= dfh_build(INSTANCE_ID);
            mem[IDX_UID_L] <= FEATURE_UID[63:0];
            mem[IDX_UID_H] <= FEATURE_UID[127:64];
        end
        else if (mmio_port.wr_en)
            mem[mmio_port.wr_idx] <= mmio_port.wr_val;
        else if (stat_port.wr_en)
            mem[stat_port.wr_idx] <= stat_port.wr_val;
    end

    a_no_wr_during_rd: assert property (@(posedge clk) disable iff (reset)
        (mmio_port.wr_en || stat_port.wr_en) |-> rd_rdy);
    a_no_rd_when_busy: assert property (@(posedge clk) disable iff (reset)
        (mmio_port.rd_en || stat_port.rd_en) |-> rd_rdy);

endmodule

// File: rtl/csr_top.sv
// ==============================
// CSR block top level
// ==============================
`timescale 1ns/1ps

module csr_top #(
    parameter int CSR_BASE = 16,
    parameter int INSTANCE_ID = 1,
    parameter int STAT_PERIOD = 1024,
    parameter int REQ_DEPTH = 64
) (
    input  logic clk,
    input  logic reset,
    // Host request
    input  logic mmio_valid,
    input  csr_pkg::mmio_op_e mmio_op,
    input  csr_pkg::mmio_addr_t mmio_addr,
    input  csr_pkg::tid_t mmio_tid,
    input  csr_pkg::csr_data_t mmio_wdata,
    // Read response
    output logic rsp_valid,
    output csr_pkg::tid_t rsp_tid,
    output csr_pkg::csr_data_t rsp_data,
    input  logic rsp_ready,
    // Events
    input  logic ev_hit_c0,
    input  logic ev_hit_c1,
    input  logic ev_miss,
    input  logic ev_walk_busy,
    // Control
    output logic mode_enable,
    output logic inval_pulse,
    output csr_pkg::csr_data_t pt_base,
    output logic pt_base_valid
);

    mmio_req_if rq ();
    stat_upd_if upd ();
    csr_mem_if mem_rsp ();
    csr_mem_if mem_stat ();

    // Decode and queue
    csr_mmio_decode #(.CSR_BASE(CSR_BASE), .REQ_DEPTH(REQ_DEPTH)) u_decode (
        .clk, .reset, .mmio_valid, .mmio_op, .mmio_addr, .mmio_tid, .mmio_wdata,
        .mode_enable, .inval_pulse, .pt_base, .pt_base_valid, .q(rq.queue));

    // Respond
    csr_mmio_responder u_responder (
        .clk, .reset, .q(rq.consumer), .mem(mem_rsp.client),
        .rsp_valid, .rsp_tid, .rsp_data, .rsp_ready);

    // Statistics side branch
    csr_event_counters #(.STAT_PERIOD(STAT_PERIOD)) u_counters (
        .clk, .reset, .ev_hit_c0, .ev_hit_c1, .ev_miss, .ev_walk_busy,
        .upd(upd.producer));

    csr_stat_folder u_folder (.clk, .reset, .upd(upd.folder), .mem(mem_stat.client));

    csr_backing_mem #(.INSTANCE_ID(INSTANCE_ID)) u_mem (
        .clk, .reset, .mmio_port(mem_rsp.mem), .stat_port(mem_stat.mem));

endmodule

// File: verif/tb_csr_top.sv
// ==============================
// CSR block testbench
// Table of host accesses, back-pressure, statistics
// ==============================
`timescale 1ns/1ps

module tb_csr_top;
    import csr_pkg::*;

    localparam int TB_BASE = 16;
    localparam int TB_INSTANCE_ID = 5;
    localparam int TB_STAT_PERIOD = 64;
    localparam int NUM_ENTRIES = 10;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 64 + 4096;

    // Entry kinds
    localparam int K_RSP = 0;
    localparam int K_NORSP = 1;
    localparam int K_MODE = 2;
    localparam int K_PTBASE = 3;

    // DFH by field: type, end-of-list, next offset, instance id
    localparam csr_data_t EXP_DFH = {4'd2, 19'd0, 1'b1, 24'(CSR_WORDS * 8), 4'd0,
                                     12'(TB_INSTANCE_ID)};

    logic clk;
    logic reset;
    logic mmio_valid;
    mmio_op_e mmio_op;
    mmio_addr_t mmio_addr;
    tid_t mmio_tid;
    csr_data_t mmio_wdata;
    logic rsp_valid;
    tid_t rsp_tid;
    csr_data_t rsp_data;
    logic rsp_ready;
    logic ev_hit_c0;
    logic ev_hit_c1;
    logic ev_miss;
    logic ev_walk_busy;
    logic mode_enable;
    logic inval_pulse;
    csr_data_t pt_base;
    logic pt_base_valid;

    // Stimulus table
    string tbl_name [NUM_ENTRIES];
    mmio_op_e tbl_op [NUM_ENTRIES];
    mmio_addr_t tbl_addr [NUM_ENTRIES];
    csr_data_t tbl_data [NUM_ENTRIES];
    csr_data_t tbl_exp [NUM_ENTRIES];
    int tbl_kind [NUM_ENTRIES];
    bit tbl_last [NUM_ENTRIES];

    // Expected and received responses, in order
    string exp_name [$];
    tid_t exp_tid [$];
    csr_data_t exp_data [$];
    bit exp_chk [$];
    tid_t rx_tid [$];
    csr_data_t rx_data [$];

    logic [15:0] lfsr_state = 16'd8301;
    tid_t next_tid = 9'h101;
    bit events_on = 1'b0;
    bit ready_rand = 1'b0;
    bit stall_q = 1'b0;
    tid_t held_tid;
    csr_data_t held_data;
    csr_data_t exp_hits = '0;
    csr_data_t exp_misses = '0;
    csr_data_t exp_walk = '0;
    int errors = 0;
    int test_err_base = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles;

    csr_top #(
        .CSR_BASE(TB_BASE),
        .INSTANCE_ID(TB_INSTANCE_ID),
        .STAT_PERIOD(TB_STAT_PERIOD),
        .REQ_DEPTH(64)
    ) dut (
        .clk(clk), .reset(reset),
        .mmio_valid(mmio_valid), .mmio_op(mmio_op), .mmio_addr(mmio_addr),
        .mmio_tid(mmio_tid), .mmio_wdata(mmio_wdata),
        .rsp_valid(rsp_valid), .rsp_tid(rsp_tid), .rsp_data(rsp_data),
        .rsp_ready(rsp_ready),
        .ev_hit_c0(ev_hit_c0), .ev_hit_c1(ev_hit_c1), .ev_miss(ev_miss),
        .ev_walk_busy(ev_walk_busy),
        .mode_enable(mode_enable), .inval_pulse(inval_pulse),
        .pt_base(pt_base), .pt_base_valid(pt_base_valid)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, x^16+x^14+x^13+x^11+1, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 16'hB400;
        return out;
    endfunction

    task automatic check(input string name, input csr_data_t exp, input csr_data_t act);
        if (exp !== act)
        begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Inputs change 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic set_entry(input int i, input string name, input mmio_op_e op,
                             input int addr, input csr_data_t data, input csr_data_t exp,
                             input int kind, input bit last);
        tbl_name[i] = name;
        tbl_op[i] = op;
        tbl_addr[i] = mmio_addr_t'(addr);
        tbl_data[i] = data;
        tbl_exp[i] = exp;
        tbl_kind[i] = kind;
        tbl_last[i] = last;
    endtask

    task automatic load_table();
        set_entry(0, "dfh", MMIO_READ, TB_BASE, '0, EXP_DFH, K_RSP, 1'b1);
        set_entry(1, "uid_low", MMIO_READ, TB_BASE + 1, '0, FEATURE_UID[63:0], K_RSP, 1'b1);
        set_entry(2, "uid_high", MMIO_READ, TB_BASE + 2, '0, FEATURE_UID[127:64], K_RSP, 1'b1);
        // Enable plus invalidate
        set_entry(3, "mode_write", MMIO_WRITE, TB_BASE + 3, 64'h3, 64'h1, K_MODE, 1'b1);
        set_entry(4, "pt_base_write", MMIO_WRITE, TB_BASE + 4, 64'h0000_0012_3456_7000,
                  64'h0000_0012_3456_7000, K_PTBASE, 1'b1);
        // Control words read back the untouched memory word
        set_entry(5, "pt_base_readback", MMIO_READ, TB_BASE + 4, '0, '0, K_RSP, 1'b1);
        // Out-of-range pair framed by two in-range reads
        set_entry(6, "oor_lead", MMIO_READ, TB_BASE, '0, EXP_DFH, K_RSP, 1'b0);
        set_entry(7, "oor_below", MMIO_READ, TB_BASE - 1, '0, '0, K_NORSP, 1'b0);
        set_entry(8, "oor_above", MMIO_READ, TB_BASE + CSR_WORDS, '0, '0, K_NORSP, 1'b0);
        set_entry(9, "out_of_range", MMIO_READ, TB_BASE + 1, '0, FEATURE_UID[63:0],
                  K_RSP, 1'b1);
    endtask

    // One host request, held for one edge
    task automatic send(input mmio_op_e op, input mmio_addr_t addr, input csr_data_t data);
        mmio_valid = 1'b1;
        mmio_op = op;
        mmio_addr = addr;
        mmio_tid = next_tid;
        mmio_wdata = data;
        next_tid = tid_t'(next_tid + 3);
        tick();
        mmio_valid = 1'b0;
    endtask

    task automatic issue_read(input string name, input mmio_addr_t addr, input csr_data_t exp,
                              input bit want_rsp, input bit chk_data);
        tid_t tid;
        tid = next_tid;
        send(MMIO_READ, addr, '0);
        if (want_rsp)
        begin
            exp_name.push_back(name);
            exp_tid.push_back(tid);
            exp_data.push_back(exp);
            exp_chk.push_back(chk_data);
        end
    endtask

    // Wait for the outstanding responses, then a quiet window
    task automatic drain(input string name);
        int waited;
        int limit;
        string nm;
        bit chk;
        csr_data_t exp;
        csr_data_t act;
        waited = 0;
        limit = 64 * exp_tid.size();
        while ((rx_tid.size() < exp_tid.size()) && (waited < limit))
        begin
            tick();
            waited++;
        end
        if (rx_tid.size() < exp_tid.size())
        begin
            $display("error: %s got %0d of %0d responses within %0d cycles", name,
                     rx_tid.size(), exp_tid.size(), limit);
            errors++;
        end
        repeat (16) tick();
        if (rx_tid.size() > exp_tid.size())
        begin
            $display("error: %s got %0d responses that were never requested", name,
                     rx_tid.size() - exp_tid.size());
            errors++;
        end
        while ((exp_tid.size() > 0) && (rx_tid.size() > 0))
        begin
            nm = exp_name.pop_front();
            chk = exp_chk.pop_front();
            exp = exp_data.pop_front();
            act = rx_data.pop_front();
            check({nm, " tid"}, csr_data_t'(exp_tid.pop_front()), csr_data_t'(rx_tid.pop_front()));
            if (chk)
                check({nm, " data"}, exp, act);
        end
        exp_name.delete();
        exp_tid.delete();
        exp_data.delete();
        exp_chk.delete();
        rx_tid.delete();
        rx_data.delete();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_base)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: failed", name);
            tests_failed++;
        end
        test_err_base = errors;
    endtask

    task automatic run_entry(input int i);
        int pulses;
        pulses = 0;
        if (tbl_op[i] == MMIO_WRITE)
        begin
            send(MMIO_WRITE, tbl_addr[i], tbl_data[i]);
            // Outputs change two edges after the sampling edge
            repeat (3)
            begin
                tick();
                if (inval_pulse)
                    pulses++;
            end
            if (tbl_kind[i] == K_MODE)
            begin
                check({tbl_name[i], " inval_pulse cycles"}, csr_data_t'(tbl_data[i][1]),
                      csr_data_t'(pulses));
                check({tbl_name[i], " mode_enable"}, tbl_exp[i], csr_data_t'(mode_enable));
            end
            else
            begin
                check({tbl_name[i], " pt_base"}, tbl_exp[i], pt_base);
                check({tbl_name[i], " pt_base_valid"}, 64'h1, csr_data_t'(pt_base_valid));
            end
            finish_test(tbl_name[i]);
        end
        else
        begin
            issue_read(tbl_name[i], tbl_addr[i], tbl_exp[i], tbl_kind[i] != K_NORSP, 1'b1);
            if (tbl_last[i])
            begin
                drain(tbl_name[i]);
                finish_test(tbl_name[i]);
            end
        end
    endtask

    // Memory contents outside the statistics words
    function automatic csr_data_t exp_word(input int idx);
        case (idx)
            0: return EXP_DFH;
            1: return FEATURE_UID[63:0];
            2: return FEATURE_UID[127:64];
            default: return '0;
        endcase
    endfunction

    // ==============================
    // Events and response side
    // ==============================
    task automatic drive_events();
        logic c0;
        logic c1;
        logic m;
        logic w;
        c0 = 1'b0;
        c1 = 1'b0;
        m = 1'b0;
        w = 1'b0;
        if (events_on)
        begin
            c0 = lfsr_bit();
            c1 = lfsr_bit();
            m = lfsr_bit();
            w = lfsr_bit();
        end
        ev_hit_c0 = c0;
        ev_hit_c1 = c1;
        ev_miss = m;
        ev_walk_busy = w;
        // Scoreboard, hits from both channels together
        exp_hits = exp_hits + csr_data_t'(c0) + csr_data_t'(c1);
        exp_misses = exp_misses + csr_data_t'(m);
        exp_walk = exp_walk + csr_data_t'(w);
    endtask

    task automatic watch_response();
        logic b0;
        logic b1;
        // A stalled response must not move
        if (stall_q)
        begin
            if (!rsp_valid)
            begin
                $display("error: rsp_valid dropped while rsp_ready was low");
                errors++;
            end
            check("stalled rsp_data", held_data, rsp_data);
            check("stalled rsp_tid", csr_data_t'(held_tid), csr_data_t'(rsp_tid));
        end
        if (ready_rand)
        begin
            b0 = lfsr_bit();
            b1 = lfsr_bit();
            rsp_ready = b0 & b1;
        end
        else
            rsp_ready = 1'b1;
        // Taken at the coming edge
        if (rsp_valid && rsp_ready)
        begin
            rx_tid.push_back(rsp_tid);
            rx_data.push_back(rsp_data);
        end
        stall_q = rsp_valid && !rsp_ready;
        held_tid = rsp_tid;
        held_data = rsp_data;
    endtask

    initial
    begin
        forever
        begin
            tick();
            if (!reset)
            begin
                drive_events();
                watch_response();
            end
        end
    end

    // Run length limit
    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ==============================
    // Main sequence
    // ==============================
    initial
    begin
        reset = 1'b1;
        mmio_valid = 1'b0;
        mmio_op = MMIO_READ;
        mmio_addr = '0;
        mmio_tid = '0;
        mmio_wdata = '0;
        rsp_ready = 1'b1;
        ev_hit_c0 = 1'b0;
        ev_hit_c1 = 1'b0;
        ev_miss = 1'b0;
        ev_walk_busy = 1'b0;
        load_table();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        tick();

        for (int i = 0; i < NUM_ENTRIES; i++)
            run_entry(i);

        // Burst of reads against a stalling host
        ready_rand = 1'b1;
        for (int i = 0; i < 10; i++)
            issue_read("backpressure", mmio_addr_t'(TB_BASE + i % 5), exp_word(i % 5), 1'b1, 1'b1);
        drain("backpressure");
        ready_rand = 1'b0;
        finish_test("backpressure");

        // Random events with reads mixed in for memory contention
        events_on = 1'b1;
        for (int c = 0; c < 3000; c++)
        begin
            if ((c % 40) == 20)
                issue_read("stat_contend", mmio_addr_t'(TB_BASE + 5 + (c / 40) % 3), '0,
                           1'b1, 1'b0);
            else
                tick();
        end
        events_on = 1'b0;
        // Quiet time so every bucket is folded
        repeat (4 * TB_STAT_PERIOD) tick();
        drain("stat_contend");
        issue_read("stat_hits", mmio_addr_t'(TB_BASE + 5), exp_hits, 1'b1, 1'b1);
        issue_read("stat_misses", mmio_addr_t'(TB_BASE + 6), exp_misses, 1'b1, 1'b1);
        issue_read("stat_walk", mmio_addr_t'(TB_BASE + 7), exp_walk, 1'b1, 1'b1);
        drain("statistics");
        finish_test("statistics");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb.f
rtl/csr_pkg.sv
rtl/csr_if.sv
rtl/csr_mmio_decode.sv
rtl/csr_mmio_responder.sv
rtl/csr_event_counters.sv
rtl/csr_stat_folder.sv
rtl/csr_backing_mem.sv
rtl/csr_top.sv
verif/tb_csr_top.sv

// File: Makefile
# Verilator build and run of the CSR block testbench

VERILATOR ?= verilator
TOP ?= tb_csr_top
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
